//--- sources.f
+incdir+.
cu_mem_pkg.sv
cu_ctrl_pkg.sv
cu_csr_decoder.sv
cu_fsm.sv
cu_mem_ctrl.sv
cu_layer_sequencer.sv
cu_top.sv
tb_cu_top.sv

//--- cu_cases.txt
// ifm_base _ ofm_base _ ifm_len _ ofm_len _ pre_dly _ cnn_dly _ post_dly, one job per line
// delays in cycles after the start level is seen, ff picks a random delay
00001000_00002000_0004_0002_03_05_02
00000100_00000200_0001_0001_00_00_00
0000fff0_00010000_0010_0008_ff_ff_ff
00003000_00004000_0000_0003_01_02_ff
00005000_00006000_0005_0000_ff_04_00
00000000_ffffffff_0000_0000_02_00_01
fffffffc_00000040_0008_0004_06_ff_03
12345678_9abcdef0_0003_0006_00_07_ff
0000a000_0000b000_0002_0002_04_01_05

//--- tb_cu_top.sv
`timescale 1ns/10ps
`include "cu_config.svh"

module tb_cu_top
    import cu_mem_pkg::*;
    import cu_ctrl_pkg::*;
();

    localparam int TIMEOUT = 500; // cycles per wait loop
    localparam int MAX_CASES = 32;

    logic      clk;
    logic      rst;
    csr_wr_t   csr;
    logic      game_state_ready;
    logic      preprocess_done, cnn_inference_done, postprocess_done;
    logic      preprocess_start, cnn_inference_start, postprocess_start;
    mem_beat_t mem_bus;
    phase_t    phase;
    logic      layer_done;
    integer    seed;
    logic [119:0] cases [0:MAX_CASES-1]; // see cu_cases.txt for the fields

    cu_top i_dut (
        .clk, .rst, .csr, .game_state_ready,
        .preprocess_done, .cnn_inference_done, .postprocess_done,
        .preprocess_start, .cnn_inference_start, .postprocess_start,
        .mem_bus, .phase, .layer_done
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH at %0t: %s = %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_beat(input mem_beat_t got, input mem_beat_t exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH at %0t: mem_bus = {valid %b write %b addr %h}, %s",
                $time, got.valid, got.write, got.addr,
                $sformatf("expected {valid %b write %b addr %h}", exp.valid, exp.write, exp.addr)));
    endtask

    task automatic check_phase(input phase_t got, input phase_t exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH at %0t: phase {fetch,compute,writeback} = %b%b%b, %s",
                $time, got.fetch, got.compute, got.writeback,
                $sformatf("expected %b%b%b", exp.fetch, exp.compute, exp.writeback)));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            stop_run($sformatf("MISMATCH at %0t: %s = %0d, expected %0d",
                $time, name, got, exp));
    endtask

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic tick();
        @(negedge clk);
    endtask

    function automatic string start_name(input int which);
        case (which)
            0:       return "preprocess_start";
            1:       return "cnn_inference_start";
            default: return "postprocess_start";
        endcase
    endfunction

    function automatic logic start_level(input int which);
        case (which)
            0:       return preprocess_start;
            1:       return cnn_inference_start;
            default: return postprocess_start;
        endcase
    endfunction

    task automatic set_done(input int which, input logic v);
        case (which)
            0:       preprocess_done = v;
            1:       cnn_inference_done = v;
            default: postprocess_done = v;
        endcase
    endtask

    // negative delay in the file means pick one at random
    function automatic int pick_delay(input logic signed [7:0] d);
        if (d < 0) return $unsigned($random(seed)) % 6;
        else       return d;
    endfunction

    task automatic check_starts(input int active); // -1 when no engine runs
        check_bit("preprocess_start", preprocess_start, active == 0);
        check_bit("cnn_inference_start", cnn_inference_start, active == 1);
        check_bit("postprocess_start", postprocess_start, active == 2);
        check_bit("layer_done", layer_done, 1'b0);
    endtask

    task automatic write_reg(input logic [1:0] idx, input logic [`CU_ADDR_W-1:0] data);
        csr.we    = 1'b1;
        csr.idx   = idx;
        csr.wdata = data;
        tick();
        csr = '0;
    endtask

    task automatic wait_start(input int which);
        int n;
        n = 0;
        while (start_level(which) !== 1'b1) begin
            if (n == TIMEOUT) begin
                stop_run($sformatf("timeout, %s never went high", start_name(which)));
            end else begin
                n++;
                tick();
            end
        end
    endtask

    // engine model answers after delay cycles with a one-cycle done
    task automatic run_engine(input int which, input int delay, input phase_t ph_exp);
        for (int i = 0; i < delay; i++) begin
            check_starts(which);
            check_phase(phase, ph_exp);
            check_bit("mem_bus.valid", mem_bus.valid, 1'b0);
            tick();
        end
        set_done(which, 1'b1);
        tick();
        set_done(which, 1'b0);
        check_bit(start_name(which), start_level(which), 1'b0);
    endtask

    task automatic check_burst(input logic write, input logic [`CU_ADDR_W-1:0] base,
                               input int len);
        int        n;
        int        cycles;
        phase_t    ph_exp;
        mem_beat_t beat_exp;
        n      = 0;
        cycles = 0;
        ph_exp = '0;
        ph_exp.fetch     = !write;
        ph_exp.writeback = write;
        check_phase(phase, ph_exp);
        while (phase === ph_exp) begin
            check_starts(-1);
            if (mem_bus.valid) begin
                beat_exp.valid = 1'b1;
                beat_exp.write = write;
                beat_exp.addr  = base + `CU_ADDR_W'(n); // wraps like the bus
                check_beat(mem_bus, beat_exp);
                n++;
            end
            if (cycles == TIMEOUT) begin
                stop_run("timeout, memory burst did not finish");
            end else begin
                cycles++;
                tick();
            end
        end
        check_count(write ? "write beats" : "read beats", n, len);
        check_bit("mem_bus.valid", mem_bus.valid, 1'b0);
    endtask

    // one idle cycle for seq start, then STEPS cycles of sequencer work
    task automatic check_compute();
        int     cycles;
        phase_t ph_exp;
        ph_exp = '0;
        check_phase(phase, ph_exp);
        check_starts(-1);
        tick();
        cycles = 1;
        ph_exp.compute = 1'b1;
        while (cnn_inference_start !== 1'b1) begin
            check_phase(phase, ph_exp);
            check_starts(-1);
            check_bit("mem_bus.valid", mem_bus.valid, 1'b0);
            if (cycles == TIMEOUT) begin
                stop_run("timeout, sequencer never handed over to the cnn engine");
            end else begin
                cycles++;
                tick();
            end
        end
        check_count("cycles from fetch end to cnn_inference_start", cycles, `CU_SEQ_STEPS + 1);
        check_phase(phase, ph_exp);
    endtask

    task automatic run_case(input logic [119:0] entry);
        logic [`CU_ADDR_W-1:0] ifm_base, ofm_base;
        logic [`CU_LEN_W-1:0]  ifm_len, ofm_len;
        logic signed [7:0]     d_pre, d_cnn, d_post;
        phase_t                idle_ph, comp_ph;
        {ifm_base, ofm_base, ifm_len, ofm_len, d_pre, d_cnn, d_post} = entry;
        idle_ph = '0;
        comp_ph = '0;
        comp_ph.compute = 1'b1;

        game_state_ready = 1'b0;
        write_reg(`CU_REG_IFM_BASE, ifm_base);
        write_reg(`CU_REG_OFM_BASE, ofm_base);
        write_reg(`CU_REG_LENS, {ofm_len, ifm_len});
        write_reg(`CU_REG_CTRL, 32'd1);
        repeat (4) begin // start is dropped while the grid is not ready
            check_starts(-1);
            check_phase(phase, idle_ph);
            check_bit("mem_bus.valid", mem_bus.valid, 1'b0);
            tick();
        end

        game_state_ready = 1'b1;
        write_reg(`CU_REG_CTRL, 32'd1);
        wait_start(0);
        run_engine(0, pick_delay(d_pre), idle_ph);
        check_burst(1'b0, ifm_base, ifm_len);
        check_compute();
        run_engine(1, pick_delay(d_cnn), comp_ph);
        wait_start(2);
        run_engine(2, pick_delay(d_post), idle_ph);
        check_burst(1'b1, ofm_base, ofm_len);

        check_bit("layer_done", layer_done, 1'b1);
        check_phase(phase, idle_ph);
        tick();
        check_bit("layer_done", layer_done, 1'b0); // single cycle
        check_starts(-1);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int n_cases;
        rst                = 1'b1;
        csr                = '0;
        game_state_ready   = 1'b0;
        preprocess_done    = 1'b0;
        cnn_inference_done = 1'b0;
        postprocess_done   = 1'b0;
        seed               = 12473;
        n_cases            = 0;
        $timeformat(-9, 0, " ns", 0);
        $readmemh("cu_cases.txt", cases);

        repeat (2) @(negedge clk);
        rst = 1'b0;
        check_starts(-1);
        check_phase(phase, '0);
        check_bit("mem_bus.valid", mem_bus.valid, 1'b0);

        // unread entries stay unknown
        while (n_cases < MAX_CASES && !$isunknown(cases[n_cases])) begin
            run_case(cases[n_cases]);
            n_cases++;
        end

        if (n_cases == 0) begin
            stop_run("no cases were read from cu_cases.txt");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- cu_top.sv
`timescale 1ns/10ps
`include "cu_config.svh"

module cu_top
    import cu_mem_pkg::*;
    import cu_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  csr_wr_t   csr,
    input  logic      game_state_ready,
    input  logic      preprocess_done,
    input  logic      cnn_inference_done,
    input  logic      postprocess_done,
    output logic      preprocess_start,
    output logic      cnn_inference_start,
    output logic      postprocess_start,
    output mem_beat_t mem_bus,
    output phase_t    phase,
    output logic      layer_done
);

    logic [`CU_ADDR_W-1:0] ifm_base, ofm_base;
    logic [`CU_LEN_W-1:0]  ifm_len, ofm_len;
    logic                  start_decoded;
    mem_req_t              rd_req, wr_req;
    logic                  rd_done, wr_done;
    logic                  seq_start, seq_done;

    cu_csr_decoder i_decoder (
        .clk, .rst, .csr,
        .ifm_base, .ofm_base, .ifm_len, .ofm_len,
        .start_decoded
    );

    cu_fsm i_fsm (
        .clk, .rst, .start_decoded, .game_state_ready,
        .preprocess_done, .cnn_inference_done, .postprocess_done,
        .rd_done, .wr_done, .seq_done,
        .ifm_base, .ofm_base, .ifm_len, .ofm_len,
        .rd_req, .wr_req, .seq_start, .phase,
        .preprocess_start, .cnn_inference_start, .postprocess_start,
        .layer_done
    );

    cu_mem_ctrl i_mem_ctrl (
        .clk, .rst, .rd_req, .wr_req,
        .rd_done, .wr_done, .mem_bus
    );

    cu_layer_sequencer i_sequencer (
        .clk, .rst, .seq_start, .seq_done
    );

endmodule

//--- cu_layer_sequencer.sv
`timescale 1ns/10ps
`include "cu_config.svh"

module cu_layer_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic seq_start,
    output logic seq_done
);

    localparam int STEPS = `CU_SEQ_STEPS;
    localparam int CNT_W = $clog2(STEPS + 1);

    logic             busy;
    logic [CNT_W-1:0] cnt; // cycles since seq_start

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (seq_start) begin
            busy <= 1'b1;
            cnt  <= 1;
        end else if (busy) begin
            if (cnt == CNT_W'(STEPS)) busy <= 1'b0;
            else                      cnt  <= cnt + 1'b1;
        end
    end

    assign seq_done = busy && (cnt == CNT_W'(STEPS));

    a_no_restart: assert property (
        @(posedge clk) disable iff (rst)
        seq_start |-> !busy
    );

endmodule

//--- cu_mem_ctrl.sv
`timescale 1ns/10ps
`include "cu_config.svh"

module cu_mem_ctrl
    import cu_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  mem_req_t  rd_req,
    input  mem_req_t  wr_req,
    output logic      rd_done,
    output logic      wr_done,
    output mem_beat_t mem_bus
);

    mem_req_t              sel_req;
    logic                  take;
    logic                  busy, wr_mode, done_q, lock;
    logic [`CU_LEN_W-1:0]  cnt, len_q;
    logic [`CU_ADDR_W-1:0] beat_addr;

    assign sel_req = rd_req.req ? rd_req : wr_req; // reads win
    assign take    = sel_req.req && !busy && !lock;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            wr_mode <= 1'b0;
            done_q  <= 1'b0;
            lock    <= 1'b0;
            cnt     <= '0;
        end else begin
            done_q <= 1'b0;
            if (take) begin
                wr_mode <= !rd_req.req;
                if (sel_req.len == '0) begin
                    done_q <= 1'b1; // nothing to move
                    lock   <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    cnt  <= 1;
                end
            end else if (busy) begin
                if (cnt == len_q) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                    lock   <= 1'b1; // hold off until req drops
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end else if (lock && !rd_req.req && !wr_req.req) begin
                lock <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            len_q     <= sel_req.len;
            beat_addr <= sel_req.addr;
        end else if (busy) begin
            beat_addr <= beat_addr + 1'b1;
        end
    end

    assign mem_bus = '{valid: busy, write: wr_mode, addr: beat_addr};
    assign rd_done = done_q && !wr_mode;
    assign wr_done = done_q && wr_mode;

    a_done_after_burst: assert property (
        @(posedge clk) disable iff (rst)
        (rd_done || wr_done) |-> $past(busy || take)
    );

endmodule

//--- cu_fsm.sv
`timescale 1ns/10ps
`include "cu_config.svh"

module cu_fsm
    import cu_mem_pkg::*;
    import cu_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start_decoded,
    input  logic                  game_state_ready,
    input  logic                  preprocess_done,
    input  logic                  cnn_inference_done,
    input  logic                  postprocess_done,
    input  logic                  rd_done,
    input  logic                  wr_done,
    input  logic                  seq_done,
    input  logic [`CU_ADDR_W-1:0] ifm_base,
    input  logic [`CU_ADDR_W-1:0] ofm_base,
    input  logic [`CU_LEN_W-1:0]  ifm_len,
    input  logic [`CU_LEN_W-1:0]  ofm_len,
    output mem_req_t              rd_req,
    output mem_req_t              wr_req,
    output logic                  seq_start,
    output phase_t                phase,
    output logic                  preprocess_start,
    output logic                  cnn_inference_start,
    output logic                  postprocess_start,
    output logic                  layer_done
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_PREPROCESS,    // game grid to cnn input
        S_FETCH_IFM,
        S_START_SEQ,
        S_WAIT_SEQ,
        S_CNN_INFERENCE,
        S_POSTPROCESS,   // cnn output to a move
        S_WRITEBACK,
        S_DONE
    } cu_state_t;

    cu_state_t state, n_state;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) state <= S_IDLE;
        else     state <= n_state;
    end

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb begin
        n_state = state;
        case (state)
            S_IDLE:          if (start_decoded && game_state_ready) n_state = S_PREPROCESS;
            S_PREPROCESS:    if (preprocess_done) n_state = S_FETCH_IFM;
            S_FETCH_IFM:     if (rd_done) n_state = S_START_SEQ;
            S_START_SEQ:     n_state = S_WAIT_SEQ;
            S_WAIT_SEQ:      if (seq_done) n_state = S_CNN_INFERENCE;
            S_CNN_INFERENCE: if (cnn_inference_done) n_state = S_POSTPROCESS;
            S_POSTPROCESS:   if (postprocess_done) n_state = S_WRITEBACK;
            S_WRITEBACK:     if (wr_done) n_state = S_DONE;
            S_DONE:          n_state = S_IDLE;
            default:         n_state = S_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // moore outputs
    ////////////////////////////////////////

    always_comb begin
        rd_req              = '0;
        wr_req              = '0;
        seq_start           = 1'b0;
        phase               = '0;
        preprocess_start    = (state == S_PREPROCESS);
        cnn_inference_start = (state == S_CNN_INFERENCE);
        postprocess_start   = (state == S_POSTPROCESS);
        layer_done          = (state == S_DONE);

        if (state == S_FETCH_IFM) begin
            rd_req      = '{req: 1'b1, addr: ifm_base, len: ifm_len};
            phase.fetch = 1'b1;
        end
        if (state == S_START_SEQ) seq_start = 1'b1;
        // compute covers the sequencer and the cnn engine
        if (state == S_WAIT_SEQ || state == S_CNN_INFERENCE) phase.compute = 1'b1;
        if (state == S_WRITEBACK) begin
            wr_req          = '{req: 1'b1, addr: ofm_base, len: ofm_len};
            phase.writeback = 1'b1;
        end
    end

    a_req_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(rd_req.req && wr_req.req)
    );

    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state inside {[S_IDLE:S_DONE]}
    );

endmodule

//--- cu_csr_decoder.sv
`timescale 1ns/10ps
`include "cu_config.svh"

module cu_csr_decoder
    import cu_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  csr_wr_t               csr,
    output logic [`CU_ADDR_W-1:0] ifm_base,
    output logic [`CU_ADDR_W-1:0] ofm_base,
    output logic [`CU_LEN_W-1:0]  ifm_len,
    output logic [`CU_LEN_W-1:0]  ofm_len,
    output logic                  start_decoded
);

    csr_word_u word;
    logic      start_hit;

    assign word      = csr.wdata;
    assign start_hit = csr.we && (csr.idx == `CU_REG_CTRL) && word.ctrl.start;

    ////////////////////////////////////////
    // register file
    ////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ifm_base      <= '0;
            ofm_base      <= '0;
            ifm_len       <= '0;
            ofm_len       <= '0;
            start_decoded <= 1'b0;
        end else begin
            start_decoded <= start_hit; // one cycle after the ctrl write
            if (csr.we) begin
                case (csr.idx)
                    `CU_REG_IFM_BASE: ifm_base <= word.base;
                    `CU_REG_OFM_BASE: ofm_base <= word.base;
                    `CU_REG_LENS: begin
                        ifm_len <= word.lens.ifm_len;
                        ofm_len <= word.lens.ofm_len;
                    end
                    default: begin
                        // ctrl only carries the start bit
                    end
                endcase
            end
        end
    end

    // start must stay a single-cycle pulse for the fsm
    a_start_pulse: assert property (
        @(posedge clk) disable iff (rst)
        start_decoded |=> !start_decoded
    );

endmodule

//--- cu_ctrl_pkg.sv
`include "cu_config.svh"

package cu_ctrl_pkg;

    // one host write, no reads on this bus
    typedef struct packed {
        logic                  we;
        logic [1:0]            idx;   // register index
        logic [`CU_ADDR_W-1:0] wdata;
    } csr_wr_t;

    typedef struct packed {
        logic [`CU_LEN_W-1:0] ofm_len; // upper half
        logic [`CU_LEN_W-1:0] ifm_len; // lower half
    } csr_lens_t;

    typedef struct packed {
        logic [`CU_ADDR_W-2:0] rsvd;
        logic                  start;
    } csr_ctrl_t;

    // the same write word, read according to idx
    typedef union packed {
        logic [`CU_ADDR_W-1:0] base;
        csr_lens_t             lens;
        csr_ctrl_t             ctrl;
    } csr_word_u;

    typedef struct packed {
        logic fetch;
        logic compute;
        logic writeback;
    } phase_t;

endpackage

//--- cu_mem_pkg.sv
`include "cu_config.svh"

package cu_mem_pkg;

    ////////////////////////////////////////
    // fsm -> memory controller
    ////////////////////////////////////////

    typedef struct packed {
        logic                  req;  // level, held until done
        logic [`CU_ADDR_W-1:0] addr; // first word of the burst
        logic [`CU_LEN_W-1:0]  len;  // beats, zero allowed
    } mem_req_t;

    ////////////////////////////////////////
    // external memory bus
    ////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic                  write; // 0 = read beat
        logic [`CU_ADDR_W-1:0] addr;
    } mem_beat_t;

endpackage

//--- cu_config.svh
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

// bus widths
`define CU_ADDR_W 32
`define CU_LEN_W  16

// register indices on the host bus
`define CU_REG_IFM_BASE 2'd0
`define CU_REG_OFM_BASE 2'd1
`define CU_REG_LENS     2'd2
`define CU_REG_CTRL     2'd3

`define CU_SEQ_STEPS 8 // compute cycles per layer

`endif
